/* common/dmem_consts.svh */
`ifndef DMEM_CONSTS_SVH
`define DMEM_CONSTS_SVH

// Number of cores sharing the data memory
`define DMEM_NCORES   4

// Cores on port A, the rest sit on port B
`define DMEM_NCORES_A 2

// Word memory geometry
`define DMEM_ADDRW    8
`define DMEM_DATAW    32

// Width of a core number
`define DMEM_COREW    2

`endif

/* common/dmem_pkg.sv */
`include "dmem_consts.svh"

package dmem_pkg;

    // One core's access request
    typedef struct packed {
        logic                   re;
        logic                   we;
        logic                   is_lr;
        logic                   is_sc;
        logic [`DMEM_ADDRW-1:0] addr;
        logic [`DMEM_DATAW-1:0] wdata;
    } core_req_t;

    // Drive of one RAM port
    typedef struct packed {
        logic                   re;
        logic                   we;
        logic [`DMEM_ADDRW-1:0] addr;
        logic [`DMEM_DATAW-1:0] wdata;
    } mem_port_t;

    // Return descriptor, one per port, one cycle behind the access
    typedef struct packed {
        logic                   valid;
        logic [`DMEM_COREW-1:0] core;
        logic                   is_sc;
        logic                   sc_ok;
    } ret_tag_t;

    // SC result word, zero on success
    typedef struct packed {
        logic [`DMEM_DATAW-2:0] zero;
        logic                   fail;
    } sc_status_t;

    // Returned word seen as load data or as SC status
    typedef union packed {
        logic [`DMEM_DATAW-1:0] word;
        sc_status_t             sc;
    } dmem_rdata_u;

endpackage

/* exec/dmem_access_exec.sv */
`timescale 1ns/1ps
`include "dmem_consts.svh"

module dmem_access_exec import dmem_pkg::*; #(
    localparam int NA      = `DMEM_NCORES_A,
    localparam int NB      = `DMEM_NCORES - `DMEM_NCORES_A,
    localparam int IDX_A_W = (NA > 1) ? $clog2(NA) : 1,
    localparam int IDX_B_W = (NB > 1) ? $clog2(NB) : 1
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  core_req_t               eff_req_i [`DMEM_NCORES],
    input  logic                    grant_a_valid_i,
    input  logic [IDX_A_W-1:0]      grant_a_idx_i,
    input  logic                    grant_b_valid_i,
    input  logic [IDX_B_W-1:0]      grant_b_idx_i,
    output logic                    advance_a_o,
    output logic                    advance_b_o,
    output logic [`DMEM_NCORES-1:0] served_o,
    output mem_port_t               port_a_o,
    output mem_port_t               port_b_o,
    output ret_tag_t                ret_a_o,
    output ret_tag_t                ret_b_o
);
    // Index 0 is port A, index 1 is port B
    logic [`DMEM_COREW-1:0]  pcore [2];
    core_req_t               preq  [2];
    mem_port_t               pport [2];
    logic [1:0]              pserve;
    logic [1:0]              pwrite;
    logic [1:0]              psc_ok;
    logic [1:0]              psc;
    logic                    conflict;
    logic [`DMEM_NCORES-1:0] resv_vld_q;
    logic [`DMEM_NCORES-1:0] resv_vld_d;
    logic [`DMEM_ADDRW-1:0]  resv_addr_q [`DMEM_NCORES];
    logic [`DMEM_ADDRW-1:0]  resv_addr_d [`DMEM_NCORES];
    ret_tag_t                ret_d [2];
    ret_tag_t                ret_q [2];

    // Port B cores follow the port A cores
    assign pcore[0] = `DMEM_COREW'(grant_a_idx_i);
    assign pcore[1] = `DMEM_COREW'(NA + grant_b_idx_i);
    assign preq[0]  = eff_req_i[pcore[0]];
    assign preq[1]  = eff_req_i[pcore[1]];

    // Same address on both ports, B backs off
    assign conflict = grant_a_valid_i & grant_b_valid_i & (preq[0].addr == preq[1].addr);
    assign pserve[0] = grant_a_valid_i;
    assign pserve[1] = grant_b_valid_i & ~conflict;

    assign advance_a_o = pserve[0];
    assign advance_b_o = pserve[1];

    always_comb begin
        served_o = '0;
        for (int p = 0; p < 2; p++) begin
            if (pserve[p]) begin
                served_o[pcore[p]] = 1'b1;
            end
        end
    end

    // RAM drive and SC decision per port
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            pport[p]  = '0;
            pwrite[p] = 1'b0;
            psc_ok[p] = 1'b0;
            psc[p]    = ~preq[p].re & preq[p].we & preq[p].is_sc;
            if (pserve[p]) begin
                pport[p].addr = preq[p].addr;
                if (preq[p].re) begin
                    pport[p].re = 1'b1;
                end else if (preq[p].we) begin
                    // SC needs its own reservation on this address
                    psc_ok[p] = psc[p] & resv_vld_q[pcore[p]]
                              & (resv_addr_q[pcore[p]] == preq[p].addr);
                    pwrite[p] = ~preq[p].is_sc | psc_ok[p];
                    pport[p].we    = pwrite[p];
                    pport[p].wdata = preq[p].wdata;
                end
            end
        end
    end

    assign port_a_o = pport[0];
    assign port_b_o = pport[1];

    // Writes kill matching reservations, LR then sets its own
    always_comb begin
        resv_vld_d  = resv_vld_q;
        resv_addr_d = resv_addr_q;
        for (int p = 0; p < 2; p++) begin
            for (int c = 0; c < `DMEM_NCORES; c++) begin
                if (pwrite[p] && (resv_addr_q[c] == preq[p].addr)) begin
                    resv_vld_d[c] = 1'b0;
                end
            end
        end
        for (int p = 0; p < 2; p++) begin
            if (pserve[p] && preq[p].re && preq[p].is_lr) begin
                resv_vld_d[pcore[p]]  = 1'b1;
                resv_addr_d[pcore[p]] = preq[p].addr;
            end
        end
    end

    // Only loads and SCs hand a word back
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            ret_d[p].valid = pserve[p] & (preq[p].re | psc[p]);
            ret_d[p].core  = pcore[p];
            ret_d[p].is_sc = psc[p];
            ret_d[p].sc_ok = psc_ok[p];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            resv_vld_q <= '0;
            ret_q[0]   <= '0;
            ret_q[1]   <= '0;
        end else begin
            resv_vld_q <= resv_vld_d;
            ret_q[0]   <= ret_d[0];
            ret_q[1]   <= ret_d[1];
        end
    end

    always_ff @(posedge clk_i) begin
        resv_addr_q <= resv_addr_d;
    end

    assign ret_a_o = ret_q[0];
    assign ret_b_o = ret_q[1];

endmodule

/* exec/dmem_port_arbiter.sv */
`timescale 1ns/1ps

module dmem_port_arbiter #(
    parameter  int N_REQ = 2,
    localparam int IDX_W = (N_REQ > 1) ? $clog2(N_REQ) : 1
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic [N_REQ-1:0] req_i,
    input  logic             advance_i,
    output logic             grant_valid_o,
    output logic [IDX_W-1:0] grant_idx_o
);
    logic [IDX_W-1:0] ptr_q;

    // First requester at or after the pointer
    always_comb begin : search
        int unsigned cand;
        grant_valid_o = 1'b0;
        grant_idx_o   = '0;
        for (int k = 0; k < N_REQ; k++) begin
            cand = ptr_q + k;
            if (cand >= N_REQ) begin
                cand = cand - N_REQ;
            end
            if (!grant_valid_o && req_i[cand]) begin
                grant_valid_o = 1'b1;
                grant_idx_o   = IDX_W'(cand);
            end
        end
    end

    // Pointer moves one past the served requester
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (advance_i) begin
            if (grant_idx_o == IDX_W'(N_REQ - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= grant_idx_o + 1'b1;
            end
        end
    end

endmodule

/* exec/dmem_ram.sv */
`timescale 1ns/1ps
`include "dmem_consts.svh"

module dmem_ram import dmem_pkg::*; (
    input  logic                   clk_i,
    input  mem_port_t              port_a_i,
    input  mem_port_t              port_b_i,
    output logic [`DMEM_DATAW-1:0] rdata_a_o,
    output logic [`DMEM_DATAW-1:0] rdata_b_o
);
    logic [`DMEM_DATAW-1:0] mem_q [1 << `DMEM_ADDRW];

    // Both ports share one array, addresses never collide on a write
    always_ff @(posedge clk_i) begin
        if (port_a_i.we) begin
            mem_q[port_a_i.addr] <= port_a_i.wdata;
        end
        if (port_b_i.we) begin
            mem_q[port_b_i.addr] <= port_b_i.wdata;
        end
        // Read word is held until the next read
        if (port_a_i.re) begin
            rdata_a_o <= mem_q[port_a_i.addr];
        end
        if (port_b_i.re) begin
            rdata_b_o <= mem_q[port_b_i.addr];
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the data-memory controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
        -f vlog.f --top-module tb_dmem_ctrl -o tb_dmem_ctrl; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_dmem_ctrl; then
    echo "Simulation failed"
    exit 1
fi

exit 0

/* source/dmem_ctrl_top.sv */
`timescale 1ns/1ps
`include "dmem_consts.svh"

module dmem_ctrl_top import dmem_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  core_req_t              req_i   [`DMEM_NCORES],
    output logic [`DMEM_DATAW-1:0] rdata_o [`DMEM_NCORES],
    output logic [`DMEM_NCORES-1:0] stall_o
);
    localparam int NA      = `DMEM_NCORES_A;
    localparam int NB      = `DMEM_NCORES - `DMEM_NCORES_A;
    localparam int IDX_A_W = (NA > 1) ? $clog2(NA) : 1;
    localparam int IDX_B_W = (NB > 1) ? $clog2(NB) : 1;

    core_req_t              eff_req [`DMEM_NCORES];
    logic [`DMEM_NCORES-1:0] req_vld;
    logic [`DMEM_NCORES-1:0] served;
    logic                   grant_a_valid;
    logic                   grant_b_valid;
    logic [IDX_A_W-1:0]     grant_a_idx;
    logic [IDX_B_W-1:0]     grant_b_idx;
    logic                   advance_a;
    logic                   advance_b;
    mem_port_t              port_a;
    mem_port_t              port_b;
    ret_tag_t               ret_a;
    ret_tag_t               ret_b;
    logic [`DMEM_DATAW-1:0] rdata_a;
    logic [`DMEM_DATAW-1:0] rdata_b;

    // Decode stage
    dmem_req_hold i_dmem_req_hold (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .served_i  (served),
        .eff_req_o (eff_req),
        .stall_o   (stall_o)
    );

    // A core requests when it reads or writes
    for (genvar c = 0; c < `DMEM_NCORES; c++) begin : g_req_vld
        assign req_vld[c] = eff_req[c].re | eff_req[c].we;
    end

    dmem_port_arbiter #(.N_REQ(NA)) i_arb_a (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (req_vld[NA-1:0]),
        .advance_i     (advance_a),
        .grant_valid_o (grant_a_valid),
        .grant_idx_o   (grant_a_idx)
    );

    dmem_port_arbiter #(.N_REQ(NB)) i_arb_b (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (req_vld[`DMEM_NCORES-1:NA]),
        .advance_i     (advance_b),
        .grant_valid_o (grant_b_valid),
        .grant_idx_o   (grant_b_idx)
    );

    dmem_access_exec i_dmem_access_exec (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .eff_req_i       (eff_req),
        .grant_a_valid_i (grant_a_valid),
        .grant_a_idx_i   (grant_a_idx),
        .grant_b_valid_i (grant_b_valid),
        .grant_b_idx_i   (grant_b_idx),
        .advance_a_o     (advance_a),
        .advance_b_o     (advance_b),
        .served_o        (served),
        .port_a_o        (port_a),
        .port_b_o        (port_b),
        .ret_a_o         (ret_a),
        .ret_b_o         (ret_b)
    );

    dmem_ram i_dmem_ram (
        .clk_i     (clk_i),
        .port_a_i  (port_a),
        .port_b_i  (port_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    dmem_return_mux i_dmem_return_mux (
        .ret_a_i   (ret_a),
        .ret_b_i   (ret_b),
        .rdata_a_i (rdata_a),
        .rdata_b_i (rdata_b),
        .rdata_o   (rdata_o)
    );

endmodule

/* source/dmem_req_hold.sv */
`timescale 1ns/1ps
`include "dmem_consts.svh"

module dmem_req_hold import dmem_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  core_req_t               req_i     [`DMEM_NCORES],
    input  logic [`DMEM_NCORES-1:0] served_i,
    output core_req_t               eff_req_o [`DMEM_NCORES],
    output logic [`DMEM_NCORES-1:0] stall_o
);
    core_req_t               pend_q [`DMEM_NCORES];
    logic [`DMEM_NCORES-1:0] pend_vld_q;
    logic [`DMEM_NCORES-1:0] has_req;
    logic [`DMEM_NCORES-1:0] miss;

    // Held request wins over the live input
    always_comb begin
        for (int c = 0; c < `DMEM_NCORES; c++) begin
            if (pend_vld_q[c]) begin
                eff_req_o[c] = pend_q[c];
            end else begin
                eff_req_o[c] = req_i[c];
            end
            has_req[c] = eff_req_o[c].re | eff_req_o[c].we;
        end
    end

    // Requests left unserved this cycle
    assign miss = has_req & ~served_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_vld_q <= '0;
            stall_o    <= '0;
        end else begin
            stall_o <= miss;
            for (int c = 0; c < `DMEM_NCORES; c++) begin
                if (served_i[c]) begin
                    pend_vld_q[c] <= 1'b0;
                end else if (miss[c]) begin
                    pend_vld_q[c] <= 1'b1;
                end
            end
        end
    end

    // Capture only a fresh input, an existing copy stays put
    always_ff @(posedge clk_i) begin
        for (int c = 0; c < `DMEM_NCORES; c++) begin
            if (miss[c] && !pend_vld_q[c]) begin
                pend_q[c] <= req_i[c];
            end
        end
    end

endmodule

/* source/dmem_return_mux.sv */
`timescale 1ns/1ps
`include "dmem_consts.svh"

module dmem_return_mux import dmem_pkg::*; (
    input  ret_tag_t               ret_a_i,
    input  ret_tag_t               ret_b_i,
    input  logic [`DMEM_DATAW-1:0] rdata_a_i,
    input  logic [`DMEM_DATAW-1:0] rdata_b_i,
    output logic [`DMEM_DATAW-1:0] rdata_o [`DMEM_NCORES]
);
    ret_tag_t               tag  [2];
    logic [`DMEM_DATAW-1:0] raw  [2];
    dmem_rdata_u            word [2];

    assign tag[0] = ret_a_i;
    assign tag[1] = ret_b_i;
    assign raw[0] = rdata_a_i;
    assign raw[1] = rdata_b_i;

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (tag[p].is_sc) begin
                // Status word, fail bit set when SC lost its reservation
                word[p].sc.zero = '0;
                word[p].sc.fail = ~tag[p].sc_ok;
            end else begin
                word[p].word = raw[p];
            end
        end

        // Ports serve disjoint cores, so at most one tag hits a core
        for (int c = 0; c < `DMEM_NCORES; c++) begin
            rdata_o[c] = '0;
            for (int p = 0; p < 2; p++) begin
                if (tag[p].valid && (tag[p].core == `DMEM_COREW'(c))) begin
                    rdata_o[c] = word[p].word;
                end
            end
        end
    end

endmodule

/* test/tb_dmem_ctrl.sv */
`timescale 1ns/1ps
`include "dmem_consts.svh"

module tb_dmem_ctrl import dmem_pkg::*; ();
    localparam int TIMEOUT = 20;

    logic                    clk;
    logic                    rst_n;
    core_req_t               req    [`DMEM_NCORES];
    logic [`DMEM_DATAW-1:0]  rdata  [`DMEM_NCORES];
    logic [`DMEM_NCORES-1:0] stall;
    logic [`DMEM_DATAW-1:0]  stored [`DMEM_NCORES];
    integer                  seed;

    dmem_ctrl_top i_dmem_ctrl_top (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .req_i   (req),
        .rdata_o (rdata),
        .stall_o (stall)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error in %s: expected %h, actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "Wrong value seen in %s", name);
        end
    endtask

    function automatic core_req_t load_req(input logic [`DMEM_ADDRW-1:0] addr, input logic lr);
        core_req_t r;
        r       = '0;
        r.re    = 1'b1;
        r.is_lr = lr;
        r.addr  = addr;
        return r;
    endfunction

    function automatic core_req_t store_req(input logic [`DMEM_ADDRW-1:0] addr,
                                            input logic [`DMEM_DATAW-1:0] wdata,
                                            input logic sc);
        core_req_t r;
        r       = '0;
        r.we    = 1'b1;
        r.is_sc = sc;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    // Drive one cycle of request and wait until the core leaves the stall
    task automatic issue_request(input int core, input core_req_t r,
                                 output logic [31:0] data, output int stalls);
        stalls = 0;
        req[core] = r;
        @(posedge clk);
        #2;
        req[core] = '0;
        while (stall[core]) begin
            if (stalls >= TIMEOUT) begin
                $display("ERRORS FOUND");
                $fatal(1, "Core %0d stayed stalled for %0d cycles", core, stalls);
            end
            @(posedge clk);
            #2;
            stalls++;
        end
        data = rdata[core];
    endtask

    // Lone request that is served at once while the other cores stay idle
    task automatic access(input string name, input int core, input core_req_t r,
                          input logic [31:0] expected);
        logic [31:0] data;
        int          stalls;
        issue_request(core, r, data, stalls);
        check_value({name, " stall cycles"}, 0, stalls);
        check_value({name, " stall flags"}, 0, 32'(stall));
        check_value(name, expected, data);
        for (int c = 0; c < `DMEM_NCORES; c++) begin
            if (c != core) begin
                check_value({name, " idle core rdata"}, 0, rdata[c]);
            end
        end
    endtask

    task automatic test_reset();
        check_value("reset stall", 0, 32'(stall));
        for (int c = 0; c < `DMEM_NCORES; c++) begin
            check_value("reset rdata", 0, rdata[c]);
        end
    endtask

    task automatic test_store_load();
        for (int c = 0; c < `DMEM_NCORES; c++) begin
            stored[c] = $random(seed);
            access("store", c, store_req(8'h10 + `DMEM_ADDRW'(c), stored[c], 1'b0), 0);
        end
        for (int c = 0; c < `DMEM_NCORES; c++) begin
            access("load", c, load_req(8'h10 + `DMEM_ADDRW'(c), 1'b0), stored[c]);
        end
    endtask

    // The loser's pending copy meets the winner's next request and goes first
    task automatic test_arbitration();
        logic [31:0] d0a, d0b, d1a, d1b;
        int          s0a, s0b, s1a, s1b;
        fork
            begin
                issue_request(0, load_req(8'h10, 1'b0), d0a, s0a);
                issue_request(0, load_req(8'h10, 1'b0), d0b, s0b);
            end
            begin
                issue_request(1, load_req(8'h11, 1'b0), d1a, s1a);
                issue_request(1, load_req(8'h11, 1'b0), d1b, s1b);
            end
        join
        check_value("arbitration stalled cores", 1, s0a + s1a);
        check_value("arbitration second stall core 0", 1, s0b);
        check_value("arbitration second stall core 1", 1, s1b);
        check_value("arbitration data core 0", stored[0], d0a);
        check_value("arbitration data core 0 again", stored[0], d0b);
        check_value("arbitration data core 1", stored[1], d1a);
        check_value("arbitration data core 1 again", stored[1], d1b);
    endtask

    task automatic test_conflict();
        logic [31:0] d0, d2;
        int          s0, s2;
        fork
            issue_request(0, load_req(8'h12, 1'b0), d0, s0);
            issue_request(2, load_req(8'h12, 1'b0), d2, s2);
        join
        check_value("conflict stall core 0", 0, s0);
        check_value("conflict stall core 2", 1, s2);
        check_value("conflict data core 0", stored[2], d0);
        check_value("conflict data core 2", stored[2], d2);
        fork
            issue_request(0, load_req(8'h10, 1'b0), d0, s0);
            issue_request(2, load_req(8'h12, 1'b0), d2, s2);
        join
        check_value("no conflict stall core 0", 0, s0);
        check_value("no conflict stall core 2", 0, s2);
        check_value("no conflict data core 0", stored[0], d0);
        check_value("no conflict data core 2", stored[2], d2);
    endtask

    task automatic test_lr_sc_pass();
        logic [31:0] fresh;
        fresh = $random(seed);
        access("lr", 2, load_req(8'h13, 1'b1), stored[3]);
        access("sc success", 2, store_req(8'h13, fresh, 1'b1), 0);
        access("load after sc", 2, load_req(8'h13, 1'b0), fresh);
        stored[3] = fresh;
    endtask

    task automatic test_lr_sc_fail();
        logic [31:0] plain;
        logic [31:0] cond;
        plain = $random(seed);
        cond  = $random(seed);
        access("lr core 1", 1, load_req(8'h11, 1'b1), stored[1]);
        // A store from the other port breaks the reservation
        access("store core 3", 3, store_req(8'h11, plain, 1'b0), 0);
        access("sc after store", 1, store_req(8'h11, cond, 1'b1), 1);
        access("load after failed sc", 1, load_req(8'h11, 1'b0), plain);
        stored[1] = plain;
        access("sc without lr", 2, store_req(8'h12, cond, 1'b1), 1);
        access("load after sc without lr", 2, load_req(8'h12, 1'b0), stored[2]);
    endtask

    initial begin
        seed  = 32'h6ceb_f8dd;
        rst_n = 1'b0;
        for (int c = 0; c < `DMEM_NCORES; c++) begin
            req[c] = '0;
        end
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset();
        test_store_load();
        test_arbitration();
        test_conflict();
        test_lr_sc_pass();
        test_lr_sc_fail();
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+common
common/dmem_pkg.sv
exec/dmem_port_arbiter.sv
exec/dmem_access_exec.sv
exec/dmem_ram.sv
source/dmem_req_hold.sv
source/dmem_return_mux.sv
source/dmem_ctrl_top.sv
test/tb_dmem_ctrl.sv
